// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_soc_top
FILELIST = filelist.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== filelist.f ====
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/block_ram.sv
verilog/seg7_display.sv
verilog/gpio_port.sv
verilog/soc_top.sv
testbench/soc_bus_assertions.sv
testbench/tb_soc_top.sv

// ==== testbench/soc_bus_assertions.sv ====
`timescale 1ns/10ps

module soc_bus_assertions (
    input logic clk_i,
    input logic rst_i,
    input logic stb_i,
    input logic cyc_i,
    input logic ack_i,
    input logic ram_stb_i,
    input logic seg_stb_i,
    input logic gpio_stb_i
);

    int failures = 0;  // assertion failures seen so far.

    // ------------------------------
    // bus handshake
    // ------------------------------

    ack_needs_request: assert property (
        @(posedge clk_i) disable iff (rst_i) ack_i |-> (stb_i && cyc_i)  // no stray ack.
    ) else begin
        failures++;
        $error("ack_o high while stb_i or cyc_i is low");
    end

    no_ack_in_reset: assert property (
        @(posedge clk_i) rst_i |-> !ack_i
    ) else begin
        failures++;
        $error("ack_o high during reset");
    end

    // The decoder priority must leave at most one window claimed.
    one_slave_strobe: assert property (
        @(posedge clk_i) disable iff (rst_i) $onehot0({ram_stb_i, seg_stb_i, gpio_stb_i})
    ) else begin
        failures++;
        $error("more than one slave strobe high");
    end

endmodule

bind soc_top soc_bus_assertions i_soc_bus_assertions (
    .clk_i(clk_i), .rst_i(rst_i), .stb_i(stb_i), .cyc_i(cyc_i), .ack_i(ack_o),
    .ram_stb_i(ram_stb), .seg_stb_i(seg_stb), .gpio_stb_i(gpio_stb)
);

// ==== testbench/tb_soc_top.sv ====
`timescale 1ns/10ps

module tb_soc_top;

    localparam int RAM_ABITS      = 10;
    localparam int GPIO_COUNT     = 24;
    localparam int SCAN_BITS      = 4;
    localparam int XFER_COUNT     = 200;  // upper bound on bus transfers in one run.
    localparam int TIMEOUT_CYCLES = XFER_COUNT * 10 + 8 * 2**SCAN_BITS + 200;

    localparam logic [31:0] RAM_ADR   = 32'h0000_1000;
    localparam logic [31:0] RAM_END   = RAM_ADR + 32'(4 * 2**RAM_ABITS);
    localparam logic [31:0] SEG_ADR   = 32'h0000_0100;
    localparam logic [31:0] GPIO_ADR  = 32'h0000_0200;
    localparam logic [31:0] HOLES [5] = '{32'h0, 32'h108, 32'h300, 32'h2000, 32'hffff_fffc};

    logic                  clk;
    logic                  rst;
    logic [31:0]           adr;
    logic [31:0]           wdat;
    logic                  we;
    logic [3:0]            sel;
    logic                  stb;
    logic                  cyc;
    logic [31:0]           rdat;
    logic                  ack;
    logic [GPIO_COUNT-1:0] gpio_in;
    logic [GPIO_COUNT-1:0] gpio_out;
    logic [GPIO_COUNT-1:0] gpio_oe;
    logic [7:0]            seg;
    logic [3:0]            an;

    logic [31:0]           rng_state;
    int                    errors;
    int                    checks;
    int                    tests;
    string                 chk_what [$];
    logic [31:0]           chk_adr [$];
    logic [31:0]           chk_exp [$];
    logic [31:0]           chk_act [$];
    logic [31:0]           chk_msk [$];

    logic [31:0]           ram_model [2**RAM_ABITS];
    logic [31:0]           ram_valid [2**RAM_ABITS];  // byte lanes written so far.
    logic [GPIO_COUNT-1:0] out_m;
    logic [GPIO_COUNT-1:0] oe_m;
    logic [15:0]           seg_val_m;
    logic [3:0]            seg_en_m;

    soc_top #(
        .RAM_ABITS(RAM_ABITS), .GPIO_COUNT(GPIO_COUNT), .SCAN_BITS(SCAN_BITS)
    ) i_soc_top (
        .clk_i(clk), .rst_i(rst), .adr_i(adr), .dat_i(wdat), .we_i(we), .sel_i(sel),
        .stb_i(stb), .cyc_i(cyc), .dat_o(rdat), .ack_o(ack), .gpio_in_i(gpio_in),
        .gpio_out_o(gpio_out), .gpio_oe_o(gpio_oe), .seg_o(seg), .an_o(an)
    );

    always #4 clk = ~clk;  // 8 ns period.

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Common anode pattern {dp, g, f, e, d, c, b, a}, zero lights a segment.
    function automatic logic [7:0] seg_pattern(input logic [3:0] hex);
        case (hex)
            4'h0: return 8'hc0;
            4'h1: return 8'hf9;
            4'h2: return 8'ha4;
            4'h3: return 8'hb0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hf8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'ha: return 8'h88;
            4'hb: return 8'h83;
            4'hc: return 8'hc6;
            4'hd: return 8'ha1;
            4'he: return 8'h86;
            default: return 8'h8e;
        endcase
    endfunction

    task automatic queue_check(input string what, input logic [31:0] a, input logic [31:0] e,
                               input logic [31:0] v, input logic [31:0] m);
        chk_what.push_back(what);
        chk_adr.push_back(a);
        chk_exp.push_back(e);
        chk_act.push_back(v);
        chk_msk.push_back(m);
    endtask

    // ------------------------------
    // compare process
    // ------------------------------

    always @(negedge clk) begin : compare
        string       what;
        logic [31:0] a, e, v, m;
        while (chk_act.size() > 0) begin
            what = chk_what.pop_front();
            a = chk_adr.pop_front();
            e = chk_exp.pop_front();
            v = chk_act.pop_front();
            m = chk_msk.pop_front();
            checks++;
            assert ((v & m) === (e & m)) else begin
                errors++;
                $display("[FAIL] %0d ns: %s at adr %08h, expected %08h, got %08h",
                         $time, what, a, e & m, v & m);
            end
        end
    end

    // ------------------------------
    // bus master
    // ------------------------------

    task automatic bus_xfer(input logic [31:0] a, input logic w, input logic [31:0] d,
                            input logic [3:0] s, output logic [31:0] r);
        int          lat;
        logic        ack_seen;
        logic [31:0] exp_lat;
        @(negedge clk);
        adr  = a;
        wdat = d;
        we   = w;
        sel  = s;
        stb  = 1'b1;
        cyc  = 1'b1;
        lat  = 0;
        ack_seen = 1'b0;
        while (!ack_seen) begin
            @(posedge clk);
            lat++;
            ack_seen = ack;  // value held over the edge that ends the cycle.
        end
        r = rdat;
        exp_lat = (a >= RAM_ADR && a < RAM_END) ? 32'd2 : 32'd1;  // RAM answers a cycle late.
        queue_check("ack latency", a, exp_lat, 32'(lat), '1);
        @(negedge clk);
        stb = 1'b0;
        cyc = 1'b0;
        we  = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [31:0] r;
        bus_xfer(a, 1'b1, d, s, r);
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] r);
        bus_xfer(a, 1'b0, 32'h0, 4'hf, r);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        repeat (2) @(negedge clk);  // let the compare process drain.
        tests++;
        $display("test %-12s %0d errors", name, errors - errs_before);
    endtask

    task automatic display_round(input logic [3:0] mask);
        logic [31:0] r;
        logic [3:0]  low;
        logic [3:0]  seen;
        r = next_random();
        bus_write(SEG_ADR, r, 4'hf);
        seg_val_m = r[15:0];
        bus_write(SEG_ADR + 32'd4, 32'(mask), 4'hf);
        seg_en_m = mask;
        bus_read(SEG_ADR, r);
        queue_check("display value", SEG_ADR, 32'(seg_val_m), r, '1);
        bus_read(SEG_ADR + 32'd4, r);
        queue_check("display enable", SEG_ADR + 32'd4, 32'(seg_en_m), r, '1);
        seen = 4'h0;
        repeat (4 * 2**SCAN_BITS) begin
            @(negedge clk);
            low = ~an;
            queue_check("anode of disabled digit", SEG_ADR, 32'h0, 32'(low & ~mask), '1);
            queue_check("more than one anode", SEG_ADR, 32'h0, 32'($countones(low) > 1), '1);
            if (low == 4'h0) begin
                queue_check("blank segments", SEG_ADR, 32'hff, 32'(seg), '1);
            end
            for (int k = 0; k < 4; k++) begin
                if (low == (4'b0001 << k)) begin
                    queue_check("segments", SEG_ADR, 32'(seg_pattern(seg_val_m[4*k +: 4])),
                                32'(seg), '1);
                end
            end
            seen = seen | low;
        end
        queue_check("digits scanned", SEG_ADR, 32'(mask), 32'(seen), '1);
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the bus transfers did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin
        logic [31:0]          r;
        logic [31:0]          d;
        logic [RAM_ABITS-1:0] word;
        logic [RAM_ABITS-1:0] touched [$];
        int                   errs0;
        clk = 1'b0;
        rst = 1'b1;
        adr = 32'h0;
        wdat = 32'h0;
        we = 1'b0;
        sel = 4'h0;
        stb = 1'b0;
        cyc = 1'b0;
        gpio_in = '0;
        rng_state = 32'd66028;
        errors = 0;
        checks = 0;
        tests = 0;
        for (int i = 0; i < 2**RAM_ABITS; i++) begin
            ram_valid[i] = 32'h0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs0 = errors;
        queue_check("ack after reset", 32'h0, 32'h0, 32'(ack), '1);
        queue_check("gpio_oe after reset", 32'h0, 32'h0, 32'(gpio_oe), '1);
        queue_check("gpio_out after reset", 32'h0, 32'h0, 32'(gpio_out), '1);
        queue_check("an after reset", 32'h0, 32'hf, 32'(an), '1);
        queue_check("seg after reset", 32'h0, 32'hff, 32'(seg), '1);
        for (int i = 0; i < 4; i++) begin
            d = (i < 2) ? SEG_ADR + 32'(4 * i) : GPIO_ADR + 32'(4 * (i - 2));
            bus_read(d, r);
            queue_check("register after reset", d, 32'h0, r, '1);
        end
        finish_test("reset state", errs0);

        errs0 = errors;
        for (int i = 0; i < 64; i++) begin
            r = next_random();
            word = r[RAM_ABITS-1:0];
            d = next_random();
            bus_write(RAM_ADR + 32'(word) * 4, d, r[15:12]);
            for (int b = 0; b < 4; b++) begin
                if (r[12 + b]) begin
                    ram_model[word][8*b +: 8] = d[8*b +: 8];
                    ram_valid[word][8*b +: 8] = 8'hff;
                end
            end
            touched.push_back(word);
        end
        foreach (touched[i]) begin
            bus_read(RAM_ADR + 32'(touched[i]) * 4, r);
            queue_check("ram read", RAM_ADR + 32'(touched[i]) * 4, ram_model[touched[i]], r,
                        ram_valid[touched[i]]);
        end
        finish_test("ram", errs0);

        errs0 = errors;
        for (int i = 0; i < 4; i++) begin
            d = next_random();
            bus_write(GPIO_ADR, d, 4'hf);
            out_m = d[GPIO_COUNT-1:0];
            queue_check("gpio_out pins", GPIO_ADR, 32'(out_m), 32'(gpio_out), '1);
            d = next_random();
            bus_write(GPIO_ADR + 32'd4, d, 4'hf);
            oe_m = d[GPIO_COUNT-1:0];
            queue_check("gpio_oe pins", GPIO_ADR + 32'd4, 32'(oe_m), 32'(gpio_oe), '1);
            bus_read(GPIO_ADR, r);
            queue_check("gpio out register", GPIO_ADR, 32'(out_m), r, '1);
            bus_read(GPIO_ADR + 32'd4, r);
            queue_check("gpio oe register", GPIO_ADR + 32'd4, 32'(oe_m), r, '1);
            d = next_random();
            gpio_in = d[GPIO_COUNT-1:0];
            repeat (2) @(negedge clk);  // two synchronizer stages.
            bus_read(GPIO_ADR + 32'd8, r);
            queue_check("gpio in register", GPIO_ADR + 32'd8, 32'(d[GPIO_COUNT-1:0]), r, '1);
            bus_read(GPIO_ADR + 32'd12, r);
            queue_check("gpio offset 3", GPIO_ADR + 32'd12, 32'h0, r, '1);
        end
        finish_test("gpio", errs0);

        errs0 = errors;
        display_round(4'b1111);
        r = next_random();
        display_round(r[3:0]);
        finish_test("display", errs0);

        errs0 = errors;
        for (int i = 0; i < 5; i++) begin
            word = HOLES[i][RAM_ABITS+1:2];  // RAM word the hole would hit if taken as RAM.
            d = next_random();
            bus_write(RAM_ADR + 32'(word) * 4, d, 4'hf);
            ram_model[word] = d;
            ram_valid[word] = 32'hffff_ffff;
        end
        for (int i = 0; i < 5; i++) begin
            bus_read(HOLES[i], r);
            queue_check("unmapped read", HOLES[i], 32'hffff_ffff, r, '1);
            bus_write(HOLES[i], next_random(), 4'hf);
        end
        bus_read(GPIO_ADR, r);
        queue_check("gpio out kept", GPIO_ADR, 32'(out_m), r, '1);
        bus_read(GPIO_ADR + 32'd4, r);
        queue_check("gpio oe kept", GPIO_ADR + 32'd4, 32'(oe_m), r, '1);
        bus_read(SEG_ADR, r);
        queue_check("display value kept", SEG_ADR, 32'(seg_val_m), r, '1);
        bus_read(SEG_ADR + 32'd4, r);
        queue_check("display enable kept", SEG_ADR + 32'd4, 32'(seg_en_m), r, '1);
        for (int i = 0; i < 5; i++) begin
            word = HOLES[i][RAM_ABITS+1:2];
            bus_read(RAM_ADR + 32'(word) * 4, r);
            queue_check("ram word kept", RAM_ADR + 32'(word) * 4, ram_model[word], r,
                        ram_valid[word]);
        end
        finish_test("unmapped", errs0);

        errors = errors + i_soc_top.i_soc_bus_assertions.failures;  // bound bus assertions.
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog/block_ram.sv ====
`timescale 1ns/10ps

module block_ram #(
    parameter int RAM_ABITS = 10
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [RAM_ABITS-1:0]          adr_i,
    input  logic [soc_pkg::DATA_W-1:0]    dat_i,
    input  logic                          we_i,
    input  logic [soc_pkg::SEL_W-1:0]     sel_i,
    input  logic                          stb_i,
    output logic [soc_pkg::DATA_W-1:0]    dat_o,
    output logic                          ack_o
);

    logic [soc_pkg::DATA_W-1:0] mem_q [2**RAM_ABITS];
    logic [soc_pkg::DATA_W-1:0] rd_q;
    logic [RAM_ABITS-1:0]       last_adr_q;
    logic                       ack_q;
    logic                       done_q;
    logic                       served;
    logic                       start;

    // A held strobe on the word just acknowledged must not be served again.
    assign served = done_q & (adr_i == last_adr_q);
    assign start  = stb_i & ~ack_q & ~served;  // first cycle of a new access.

    // ------------------------------
    // storage and read port
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (start) begin
            if (we_i) begin
                for (int b = 0; b < soc_pkg::SEL_W; b++) begin
                    if (sel_i[b]) begin
                        mem_q[adr_i][8*b +: 8] <= dat_i[8*b +: 8];  // enabled lanes only.
                    end
                end
            end
            rd_q       <= mem_q[adr_i];  // old word, only meaningful on reads.
            last_adr_q <= adr_i;
        end
    end

    // ------------------------------
    // acknowledge
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q <= start;                // one cycle after the strobe is seen.
            if (!stb_i) begin
                done_q <= 1'b0;            // strobe dropped, ready for a new access.
            end else if (ack_q) begin
                done_q <= 1'b1;
            end
        end
    end

    assign dat_o = rd_q;
    assign ack_o = ack_q;

endmodule

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/10ps

module bus_decoder #(
    parameter int RAM_ABITS = 10
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    // master side
    input  logic [soc_pkg::ADR_W-1:0]     adr_i,
    input  logic [soc_pkg::DATA_W-1:0]    dat_i,
    input  logic                          we_i,
    input  logic [soc_pkg::SEL_W-1:0]     sel_i,
    input  logic                          stb_i,
    input  logic                          cyc_i,
    output logic [soc_pkg::DATA_W-1:0]    dat_o,
    output logic                          ack_o,
    // slave side
    output logic [RAM_ABITS-1:0]          word_adr_o,
    output logic [soc_pkg::DATA_W-1:0]    wdat_o,
    output logic                          we_o,
    output logic [soc_pkg::SEL_W-1:0]     sel_o,
    output logic                          ram_stb_o,
    output logic                          seg_stb_o,
    output logic                          gpio_stb_o,
    input  logic [soc_pkg::DATA_W-1:0]    ram_dat_i,
    input  logic                          ram_ack_i,
    input  logic [soc_pkg::DATA_W-1:0]    seg_dat_i,
    input  logic [soc_pkg::DATA_W-1:0]    gpio_dat_i
);

    // The RAM window spans 2**RAM_ABITS words, so clear the low byte-address bits.
    localparam logic [soc_pkg::ADR_W-1:0] RAM_MASK =
        {soc_pkg::ADR_W{1'b1}} << (RAM_ABITS + 2);

    logic stb_cyc;
    logic gpio_match, seg_match, ram_match;
    logic gpio_sel, seg_sel, ram_sel, def_sel;
    logic ram_sel_q;

    assign stb_cyc = stb_i & cyc_i;

    // ------------------------------
    // window match, in priority order
    // ------------------------------

    assign gpio_match = (adr_i & soc_pkg::GPIO_MASK) == soc_pkg::GPIO_BASE;
    assign seg_match  = (adr_i & soc_pkg::SEG7_MASK) == soc_pkg::SEG7_BASE;
    assign ram_match  = (adr_i & RAM_MASK) == soc_pkg::RAM_BASE;

    assign gpio_sel = gpio_match;
    assign seg_sel  = ~gpio_match & seg_match;
    assign ram_sel  = ~gpio_match & ~seg_match & ram_match;
    assign def_sel  = ~gpio_match & ~seg_match & ~ram_match;  // nothing else claimed it.

    assign gpio_stb_o = stb_cyc & gpio_sel;
    assign seg_stb_o  = stb_cyc & seg_sel;
    assign ram_stb_o  = stb_cyc & ram_sel;

    // shared slave request.
    assign word_adr_o = adr_i[RAM_ABITS+1:2];
    assign wdat_o     = dat_i;
    assign we_o       = we_i;
    assign sel_o      = sel_i;

    // Remember that the RAM held the bus last cycle, so its late ack is only
    // taken for the transfer that is still addressed to it.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ram_sel_q <= 1'b0;
        end else begin
            ram_sel_q <= ram_stb_o;
        end
    end

    // ------------------------------
    // return path
    // ------------------------------

    always_comb begin
        if (gpio_sel) begin
            dat_o = gpio_dat_i;
        end else if (seg_sel) begin
            dat_o = seg_dat_i;
        end else if (ram_sel) begin
            dat_o = ram_dat_i;
        end else begin
            dat_o = soc_pkg::UNMAPPED_DATA;     // default slave.
        end
    end

    // register slaves and the default slave answer at once.
    assign ack_o = stb_cyc &
                   ((ram_sel & ram_sel_q & ram_ack_i) | gpio_sel | seg_sel | def_sel);

endmodule

// ==== verilog/gpio_port.sv ====
`timescale 1ns/10ps

module gpio_port #(
    parameter int GPIO_COUNT = 24
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [1:0]                    adr_i,
    input  logic [soc_pkg::DATA_W-1:0]    dat_i,
    input  logic                          we_i,
    input  logic                          stb_i,
    input  logic [GPIO_COUNT-1:0]         gpio_in_i,
    output logic [soc_pkg::DATA_W-1:0]    dat_o,
    output logic [GPIO_COUNT-1:0]         gpio_out_o,
    output logic [GPIO_COUNT-1:0]         gpio_oe_o
);

    logic [GPIO_COUNT-1:0] out_q;
    logic [GPIO_COUNT-1:0] oe_q;
    logic [GPIO_COUNT-1:0] sync1_q;
    logic [GPIO_COUNT-1:0] sync2_q;

    // ------------------------------
    // output side
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_q <= '0;
            oe_q  <= '0;                   // all pins start as inputs.
        end else if (stb_i && we_i) begin
            if (adr_i == soc_pkg::GPIO_REG_OUT) begin
                out_q <= dat_i[GPIO_COUNT-1:0];
            end else if (adr_i == soc_pkg::GPIO_REG_OE) begin
                oe_q <= dat_i[GPIO_COUNT-1:0];
            end
        end
    end

    assign gpio_out_o = out_q;
    assign gpio_oe_o  = oe_q;

    // ------------------------------
    // input side
    // ------------------------------

    // Pins are asynchronous to clk_i, two flops settle them.
    always_ff @(posedge clk_i) begin
        sync1_q <= gpio_in_i;
        sync2_q <= sync1_q;
    end

    always_comb begin
        dat_o = '0;                        // offset 3 and unused upper bits read zero.
        case (adr_i)
            soc_pkg::GPIO_REG_OUT: dat_o[GPIO_COUNT-1:0] = out_q;
            soc_pkg::GPIO_REG_OE:  dat_o[GPIO_COUNT-1:0] = oe_q;
            soc_pkg::GPIO_REG_IN:  dat_o[GPIO_COUNT-1:0] = sync2_q;
            default:               dat_o = '0;
        endcase
    end

endmodule

// ==== verilog/seg7_display.sv ====
`timescale 1ns/10ps

module seg7_display #(
    parameter int SCAN_BITS = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          adr_i,
    input  logic [soc_pkg::DATA_W-1:0]    dat_i,
    input  logic                          we_i,
    input  logic                          stb_i,
    output logic [soc_pkg::DATA_W-1:0]    dat_o,
    output logic [7:0]                    seg_o,
    output logic [3:0]                    an_o
);

    logic [15:0]          value_q;
    logic [3:0]           enable_q;
    logic [SCAN_BITS-1:0] scan_q;
    logic [1:0]           digit_q;
    logic [3:0]           nibble;
    logic                 digit_on;

    // Segment pattern in the order g f e d c b a, one means lit.
    function automatic logic [6:0] hex_font(input logic [3:0] hex);
        case (hex)
            4'h0:    hex_font = 7'h3f;
            4'h1:    hex_font = 7'h06;
            4'h2:    hex_font = 7'h5b;
            4'h3:    hex_font = 7'h4f;
            4'h4:    hex_font = 7'h66;
            4'h5:    hex_font = 7'h6d;
            4'h6:    hex_font = 7'h7d;
            4'h7:    hex_font = 7'h07;
            4'h8:    hex_font = 7'h7f;
            4'h9:    hex_font = 7'h6f;
            4'ha:    hex_font = 7'h77;
            4'hb:    hex_font = 7'h7c;  // lower case b.
            4'hc:    hex_font = 7'h39;
            4'hd:    hex_font = 7'h5e;  // lower case d.
            4'he:    hex_font = 7'h79;
            default: hex_font = 7'h71;
        endcase
    endfunction

    // ------------------------------
    // bus registers
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            value_q  <= '0;
            enable_q <= '0;
        end else if (stb_i && we_i) begin
            if (adr_i == soc_pkg::SEG7_REG_VALUE) begin
                value_q <= dat_i[15:0];
            end else begin
                enable_q <= dat_i[3:0];
            end
        end
    end

    assign dat_o = (adr_i == soc_pkg::SEG7_REG_VALUE) ? {16'h0000, value_q}
                                                      : {28'h0000000, enable_q};

    // ------------------------------
    // digit scan
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            scan_q  <= '0;
            digit_q <= 2'd0;
        end else begin
            scan_q <= scan_q + 1'b1;
            if (&scan_q) begin
                digit_q <= digit_q + 2'd1;  // next digit once the prescaler wraps.
            end
        end
    end

    assign nibble   = value_q[4*digit_q +: 4];
    assign digit_on = enable_q[digit_q];

    // Anodes and segments are active low, the decimal point stays dark.
    assign an_o  = digit_on ? ~(4'b0001 << digit_q) : 4'b1111;
    assign seg_o = digit_on ? {1'b1, ~hex_font(nibble)} : 8'hff;

endmodule

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

    // ------------------------------
    // bus geometry
    // ------------------------------

    localparam int ADR_W  = 32;          // byte address width on the master bus.
    localparam int DATA_W = 32;          // one bus word.
    localparam int SEL_W  = DATA_W / 8;  // one select bit per byte lane.

    // ------------------------------
    // address map, byte addresses
    // ------------------------------

    // A window matches when (adr & MASK) == BASE.
    localparam logic [ADR_W-1:0] GPIO_BASE = 32'h0000_0200;
    localparam logic [ADR_W-1:0] GPIO_MASK = 32'hffff_fff0;  // four words.
    localparam logic [ADR_W-1:0] SEG7_BASE = 32'h0000_0100;
    localparam logic [ADR_W-1:0] SEG7_MASK = 32'hffff_fff8;  // two words.

    // the RAM mask depends on RAM_ABITS and is built in the decoder.
    localparam logic [ADR_W-1:0] RAM_BASE  = 32'h0000_1000;

    // ------------------------------
    // register word offsets
    // ------------------------------

    localparam logic [1:0] GPIO_REG_OUT = 2'd0;  // output latch.
    localparam logic [1:0] GPIO_REG_OE  = 2'd1;  // output enable, 1 drives the pin.
    localparam logic [1:0] GPIO_REG_IN  = 2'd2;  // synchronized pin state, read only.

    localparam logic SEG7_REG_VALUE  = 1'b0;     // four hex digits in bits 15:0.
    localparam logic SEG7_REG_ENABLE = 1'b1;     // one enable bit per digit.

    // Read data of the default slave.
    localparam logic [DATA_W-1:0] UNMAPPED_DATA = '1;

endpackage

// ==== verilog/soc_top.sv ====
`timescale 1ns/10ps

module soc_top #(
    parameter int RAM_ABITS  = 10,
    parameter int GPIO_COUNT = 24,
    parameter int SCAN_BITS  = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    // bus master port
    input  logic [soc_pkg::ADR_W-1:0]     adr_i,
    input  logic [soc_pkg::DATA_W-1:0]    dat_i,
    input  logic                          we_i,
    input  logic [soc_pkg::SEL_W-1:0]     sel_i,
    input  logic                          stb_i,
    input  logic                          cyc_i,
    output logic [soc_pkg::DATA_W-1:0]    dat_o,
    output logic                          ack_o,
    // board pins
    input  logic [GPIO_COUNT-1:0]         gpio_in_i,
    output logic [GPIO_COUNT-1:0]         gpio_out_o,
    output logic [GPIO_COUNT-1:0]         gpio_oe_o,
    output logic [7:0]                    seg_o,
    output logic [3:0]                    an_o
);

    // ------------------------------
    // decoder to slave wiring
    // ------------------------------

    logic [RAM_ABITS-1:0]       word_adr;   // the slaves take the low bits they need.
    logic [soc_pkg::DATA_W-1:0] wdat;
    logic                       we;
    logic [soc_pkg::SEL_W-1:0]  sel;
    logic                       ram_stb, seg_stb, gpio_stb;
    logic [soc_pkg::DATA_W-1:0] ram_dat, seg_dat, gpio_dat;
    logic                       ram_ack;

    bus_decoder #(.RAM_ABITS(RAM_ABITS)) i_bus_decoder (
        .clk_i      ( clk_i    ), .rst_i      ( rst_i    ),
        .adr_i      ( adr_i    ), .dat_i      ( dat_i    ),
        .we_i       ( we_i     ), .sel_i      ( sel_i    ),
        .stb_i      ( stb_i    ), .cyc_i      ( cyc_i    ),
        .dat_o      ( dat_o    ), .ack_o      ( ack_o    ),
        .word_adr_o ( word_adr ), .wdat_o     ( wdat     ),
        .we_o       ( we       ), .sel_o      ( sel      ),
        .ram_stb_o  ( ram_stb  ), .seg_stb_o  ( seg_stb  ),
        .gpio_stb_o ( gpio_stb ),
        .ram_dat_i  ( ram_dat  ), .ram_ack_i  ( ram_ack  ),
        .seg_dat_i  ( seg_dat  ), .gpio_dat_i ( gpio_dat )
    );

    // ------------------------------
    // slaves
    // ------------------------------

    block_ram #(.RAM_ABITS(RAM_ABITS)) i_block_ram (
        .clk_i ( clk_i    ), .rst_i ( rst_i   ),
        .adr_i ( word_adr ), .dat_i ( wdat    ),
        .we_i  ( we       ), .sel_i ( sel     ),
        .stb_i ( ram_stb  ), .dat_o ( ram_dat ),
        .ack_o ( ram_ack  )
    );

    seg7_display #(.SCAN_BITS(SCAN_BITS)) i_seg7_display (
        .clk_i ( clk_i       ), .rst_i ( rst_i   ),
        .adr_i ( word_adr[0] ), .dat_i ( wdat    ),
        .we_i  ( we          ), .stb_i ( seg_stb ),
        .dat_o ( seg_dat     ), .seg_o ( seg_o   ),
        .an_o  ( an_o        )
    );

    gpio_port #(.GPIO_COUNT(GPIO_COUNT)) i_gpio_port (
        .clk_i      ( clk_i         ), .rst_i     ( rst_i     ),
        .adr_i      ( word_adr[1:0] ), .dat_i     ( wdat      ),
        .we_i       ( we            ), .stb_i     ( gpio_stb  ),
        .gpio_in_i  ( gpio_in_i     ), .dat_o     ( gpio_dat  ),
        .gpio_out_o ( gpio_out_o    ), .gpio_oe_o ( gpio_oe_o )
    );

endmodule
